// ==== Makefile ====
# Verilator flow for the CSR index configuration collector

VERILATOR := verilator
FLAGS     := --timing
TOP       := tb_csr_index_configure
FILE_LIST := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+logic
logic/mem_pkg.sv
logic/engine_pkg.sv
logic/response_filter.sv
logic/sync_fifo.sv
logic/config_assembler.sv
logic/csr_index_configure_top.sv
verif/tb_csr_index_configure.sv

// ==== logic/config_assembler.sv ====
// ----------------------------------------------------------
// Configuration assembly with completion mask, output push
// and response pop gating
// ----------------------------------------------------------

`include "csr_config.svh"

module config_assembler (
    input  logic                          ap_clk,
    input  logic                          areset_csr_index_generator,
    input  logic                          word_valid,
    input  mem_pkg::memory_response_t     word,
    input  engine_pkg::seq_index_t        word_seq,
    input  logic                          response_rd_en,
    input  logic                          configuration_rd_en,
    input  logic                          out_prog_full,
    output logic                          response_pop,
    output logic                          configuration_pop,
    output logic                          config_push,
    output engine_pkg::csr_index_config_t config_payload
);

    import engine_pkg::*;

    localparam int IDX_W = $clog2(`CSR_SEQ_COUNT);

    typedef logic [IDX_W-1:0] idx_t;

    logic         response_rd_en_reg;
    logic         configuration_rd_en_reg;
    config_mask_t mask;
    config_mask_t mask_next;
    seq_index_t   seq_rel;
    logic         word_hit;
    idx_t         word_idx;

    // ------------------------------------------------------------
    // Read enable registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            response_rd_en_reg      <= 1'b0;
            configuration_rd_en_reg <= 1'b0;
        end else begin
            response_rd_en_reg      <= response_rd_en;
            configuration_rd_en_reg <= configuration_rd_en;
        end
    end

    assign configuration_pop = configuration_rd_en_reg;

    // No reads while emitting or while the output queue is nearly full
    assign config_push  = &mask;
    assign response_pop = response_rd_en_reg && !config_push && !out_prog_full;

    // ------------------------------------------------------------
    // Word decode
    // ------------------------------------------------------------
    assign seq_rel  = word_seq - seq_index_t'(`CSR_SEQ_MIN);
    assign word_hit = word_valid && (seq_rel < seq_index_t'(`CSR_SEQ_COUNT));
    assign word_idx = seq_rel[IDX_W-1:0];

    // A word landing on the push edge starts the next mask
    always_comb begin
        mask_next = config_push ? '0 : mask;
        if (word_hit) begin
            mask_next[word_idx] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            mask <= '0;
        end else begin
            mask <= mask_next;
        end
    end

    // Field registers, last write wins
    always_ff @(posedge ap_clk) begin
        if (word_hit) begin
            case (word_idx)
                idx_t'(0): config_payload.flags <= engine_flags_t'(word.data[3:0]);
                idx_t'(1): config_payload.index_start <= word.data;
                idx_t'(2): config_payload.index_end <= word.data;
                idx_t'(3): config_payload.stride <= word.data;
                idx_t'(4): begin
                    config_payload.granularity     <= word.data[`CSR_DATA_W-2:0];
                    config_payload.shift_direction <= word.data[`CSR_DATA_W-1];
                end
                idx_t'(5): config_payload.array_pointer[`CSR_DATA_W-1:0] <= word.data;
                idx_t'(6): begin
                    config_payload.array_pointer[`CSR_ADDR_W-1:`CSR_DATA_W] <= word.data;
                end
                default: config_payload.array_size <= word.data;
            endcase
        end
    end

endmodule

// ==== logic/csr_config.svh ====
// ----------------------------------------------------------
// Widths, sequence window and queue sizes for the
// CSR index configuration collector
// ----------------------------------------------------------

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Datapath widths
`define CSR_DATA_W      32
`define CSR_ADDR_W      64
`define CSR_OFFSET_W    16
`define CSR_SHIFT_W     5

// Accepted sequence window, one word per configuration field
`define CSR_SEQ_MIN     0
`define CSR_SEQ_COUNT   8

// Response and configuration queues
`define CSR_FIFO_DEPTH  16
`define CSR_PROG_THRESH 8

`endif

// ==== logic/csr_index_configure_top.sv ====
// ----------------------------------------------------------
// Top level of the collector: response filter, response and
// configuration queues, configuration assembler
// ----------------------------------------------------------

`include "csr_config.svh"

module csr_index_configure_top (
    input  logic                          ap_clk,
    input  logic                          areset_csr_index_generator,
    input  logic                          response_valid,
    input  mem_pkg::memory_response_t     response_payload,
    input  logic                          response_rd_en,
    input  logic                          configuration_rd_en,
    output logic                          configuration_valid,
    output engine_pkg::csr_index_config_t configuration_payload,
    output logic                          response_prog_full,
    output logic                          configuration_prog_full
);

    import mem_pkg::*;
    import engine_pkg::*;

    logic              filter_push;
    memory_response_t  filter_payload;
    logic              response_pop;
    memory_response_t  response_dout;
    logic              response_dout_valid;
    logic              configuration_pop;
    logic              config_push;
    csr_index_config_t config_din;

    response_filter u_response_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_payload           (response_payload),
        .push                       (filter_push),
        .push_payload               (filter_payload),
        .seq_index                  ()
    );

    // ------------------------------------------------------------
    // Response queue
    // ------------------------------------------------------------
    sync_fifo #(
        .payload_t   (memory_response_t),
        .DEPTH       (`CSR_FIFO_DEPTH),
        .PROG_THRESH (`CSR_PROG_THRESH)
    ) response_queue (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .wr_en                      (filter_push),
        .din                        (filter_payload),
        .rd_en                      (response_pop),
        .dout                       (response_dout),
        .valid                      (response_dout_valid),
        .full                       (),
        .empty                      (),
        .prog_full                  (response_prog_full)
    );

    // Queued offset already holds the sequence number
    config_assembler u_config_assembler (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .word_valid                 (response_dout_valid),
        .word                       (response_dout),
        .word_seq                   (seq_index_t'(response_dout.offset)),
        .response_rd_en             (response_rd_en),
        .configuration_rd_en        (configuration_rd_en),
        .out_prog_full              (configuration_prog_full),
        .response_pop               (response_pop),
        .configuration_pop          (configuration_pop),
        .config_push                (config_push),
        .config_payload             (config_din)
    );

    // ------------------------------------------------------------
    // Configuration queue
    // ------------------------------------------------------------
    sync_fifo #(
        .payload_t   (csr_index_config_t),
        .DEPTH       (`CSR_FIFO_DEPTH),
        .PROG_THRESH (`CSR_PROG_THRESH)
    ) configuration_queue (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .wr_en                      (config_push),
        .din                        (config_din),
        .rd_en                      (configuration_pop),
        .dout                       (configuration_payload),
        .valid                      (configuration_valid),
        .full                       (),
        .empty                      (),
        .prog_full                  (configuration_prog_full)
    );

endmodule

// ==== logic/engine_pkg.sv ====
// ----------------------------------------------------------
// Configuration flag, sequence and payload types of the
// CSR index engine
// ----------------------------------------------------------

`include "csr_config.svh"

package engine_pkg;

    // Sequence number of a configuration word
    typedef logic [`CSR_OFFSET_W-1:0] seq_index_t;

    // One bit per configuration word seen
    typedef logic [`CSR_SEQ_COUNT-1:0] config_mask_t;

    // Bit 0 is increment, bit 3 is mode buffer
    typedef struct packed {
        logic mode_buffer;
        logic mode_sequence;
        logic decrement;
        logic increment;
    } engine_flags_t;

    // ------------------------------------------------------------
    // Assembled configuration
    // ------------------------------------------------------------
    typedef struct packed {
        engine_flags_t           flags;
        logic [`CSR_DATA_W-1:0]  index_start;
        logic [`CSR_DATA_W-1:0]  index_end;
        logic [`CSR_DATA_W-1:0]  stride;
        logic [`CSR_DATA_W-2:0]  granularity;
        logic                    shift_direction;
        logic [`CSR_ADDR_W-1:0]  array_pointer;
        logic [`CSR_DATA_W-1:0]  array_size;
    } csr_index_config_t;

endpackage

// ==== logic/mem_pkg.sv ====
// ----------------------------------------------------------
// Memory response types seen at the lane input
// ----------------------------------------------------------

`include "csr_config.svh"

package mem_pkg;

    // Buffer class attached to each memory response
    typedef enum logic [2:0] {
        class_invalid      = 3'd0,
        class_cu_setup     = 3'd1,
        class_engine_setup = 3'd2,
        class_data         = 3'd3
    } buffer_class_t;

    typedef logic [`CSR_OFFSET_W-1:0] mem_offset_t;
    typedef logic [`CSR_SHIFT_W-1:0]  mem_shift_t;
    typedef logic [`CSR_DATA_W-1:0]   mem_data_t;

    // ------------------------------------------------------------
    // One response word
    // ------------------------------------------------------------
    // Sequence number is offset >> shift_amount
    typedef struct packed {
        buffer_class_t buffer_class;
        mem_offset_t   offset;
        mem_shift_t    shift_amount;
        mem_data_t     data;
    } memory_response_t;

endpackage

// ==== logic/response_filter.sv ====
// ----------------------------------------------------------
// Response input register, sequence computation and
// setup-class window filter
// ----------------------------------------------------------

`include "csr_config.svh"

module response_filter (
    input  logic                      ap_clk,
    input  logic                      areset_csr_index_generator,
    input  logic                      response_valid,
    input  mem_pkg::memory_response_t response_payload,
    output logic                      push,
    output mem_pkg::memory_response_t push_payload,
    output engine_pkg::seq_index_t    seq_index
);

    import mem_pkg::*;
    import engine_pkg::*;

    logic             response_valid_reg;
    memory_response_t response_reg;
    seq_index_t       seq_rel;
    logic             setup_class;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            response_valid_reg <= 1'b0;
        end else begin
            response_valid_reg <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_reg <= response_payload;
    end

    // ------------------------------------------------------------
    // Sequence and filter
    // ------------------------------------------------------------
    assign seq_index = response_reg.offset >> response_reg.shift_amount;

    // Below the window start this wraps high, so one compare covers both ends
    assign seq_rel = seq_index - seq_index_t'(`CSR_SEQ_MIN);

    assign setup_class = (response_reg.buffer_class == class_cu_setup) ||
                         (response_reg.buffer_class == class_engine_setup);

    assign push = response_valid_reg && setup_class &&
                  (seq_rel < seq_index_t'(`CSR_SEQ_COUNT));

    // Downstream the offset field holds the sequence number, unshifted
    always_comb begin
        push_payload              = response_reg;
        push_payload.offset       = seq_index;
        push_payload.shift_amount = '0;
    end

endmodule

// ==== logic/sync_fifo.sv ====
// ----------------------------------------------------------
// Synchronous queue with a type parameter, registered read
// with valid strobe, and a programmable full level
// ----------------------------------------------------------

module sync_fifo #(
    parameter type payload_t   = logic [7:0],
    parameter int  DEPTH       = 16,
    parameter int  PROG_THRESH = 8
) (
    input  logic     ap_clk,
    input  logic     areset_csr_index_generator,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     valid,
    output logic     full,
    output logic     empty,
    output logic     prog_full
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);

    typedef logic [ADDR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0]  count_t;

    payload_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;
    logic     wr_ok;
    logic     rd_ok;

    // Full queue drops writes, empty queue ignores reads
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign full      = (count == count_t'(DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= count_t'(PROG_THRESH));

    // ------------------------------------------------------------
    // Pointers, count and read strobe
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// ==== verif/csr_golden.txt ====
# W class offset shift data : one response word per cycle, hex (class 1 cu, 2 engine, 3 data)
# E flags start end stride gran dir pointer size : expected configuration, hex
# P cycles level : hold configuration reads low, then expect configuration_prog_full = level
P 110 1
# In order set, flags from low nibble only
W 1 0000 00 fffffff5
W 1 0001 00 00000010
W 1 0002 00 00000200
W 1 0003 00 00000004
W 1 0004 00 80000003
W 1 0005 00 cafe0000
W 1 0006 00 00000012
W 1 0007 00 00001000
E 5 00000010 00000200 00000004 00000003 1 00000012cafe0000 00001000
# Out of order with repeats, last write wins
W 2 0007 00 00002000
W 2 0003 00 00000008
W 2 0000 00 0000000a
W 2 0003 00 00000010
W 2 0001 00 00000020
W 2 0004 00 00000007
W 2 0000 00 00000003
W 2 0006 00 00000001
W 2 0002 00 00000400
W 2 0005 00 00001000
E 3 00000020 00000400 00000010 00000007 0 0000000100001000 00002000
# Rejected words, then a set addressed with shift 2
W 3 0001 00 deadbeef
W 1 0008 00 deadbeef
W 2 0040 03 deadbeef
W 1 0000 02 00000009
W 1 0004 02 00000030
W 1 0008 02 00000300
W 1 000c 02 00000002
W 1 0010 02 fffffffe
W 1 0014 02 00004000
W 1 0018 02 00000000
W 1 001c 02 00000040
E 9 00000030 00000300 00000002 7ffffffe 1 0000000000004000 00000040
W 2 0000 00 00000041
W 2 0001 00 00000041
W 2 0002 00 00000042
W 2 0003 00 00000043
W 2 0004 00 00000044
W 2 0005 00 00000045
W 2 0006 00 00000046
W 2 0007 00 00000047
E 1 00000041 00000042 00000043 00000044 0 0000004600000045 00000047
W 1 0000 00 00000052
W 1 0001 00 00000051
W 1 0002 00 00000052
W 1 0003 00 00000053
W 1 0004 00 00000054
W 1 0005 00 00000055
W 1 0006 00 00000056
W 1 0007 00 00000057
E 2 00000051 00000052 00000053 00000054 0 0000005600000055 00000057
W 2 0000 00 00000063
W 2 0001 00 00000061
W 2 0002 00 00000062
W 2 0003 00 00000063
W 2 0004 00 00000064
W 2 0005 00 00000065
W 2 0006 00 00000066
W 2 0007 00 00000067
E 3 00000061 00000062 00000063 00000064 0 0000006600000065 00000067
W 1 0000 00 00000074
W 1 0001 00 00000071
W 1 0002 00 00000072
W 1 0003 00 00000073
W 1 0004 00 00000074
W 1 0005 00 00000075
W 1 0006 00 00000076
W 1 0007 00 00000077
E 4 00000071 00000072 00000073 00000074 0 0000007600000075 00000077
W 2 0000 00 00000085
W 2 0001 00 00000081
W 2 0002 00 00000082
W 2 0003 00 00000083
W 2 0004 00 00000084
W 2 0005 00 00000085
W 2 0006 00 00000086
W 2 0007 00 00000087
E 5 00000081 00000082 00000083 00000084 0 0000008600000085 00000087

// ==== verif/tb_csr_index_configure.sv ====
// ----------------------------------------------------------
// Testbench for the CSR index configuration collector:
// golden-file driver, configuration monitor, compare tasks
// ----------------------------------------------------------

`include "csr_config.svh"

module tb_csr_index_configure;

    import mem_pkg::*;
    import engine_pkg::*;

    localparam string GOLDEN_FILE = "verif/csr_golden.txt";

    logic              ap_clk = 1'b0;
    logic              areset_csr_index_generator;
    logic              response_valid;
    memory_response_t  response_payload;
    logic              response_rd_en;
    logic              configuration_rd_en;
    logic              configuration_valid;
    csr_index_config_t configuration_payload;
    logic              response_prog_full;
    logic              configuration_prog_full;

    // Expected configurations, oldest first
    csr_index_config_t expected_q[$];

    // Words the filter must drop, held back until a set is one word short
    memory_response_t  rejected_q[$];
    logic [`CSR_SEQ_COUNT-1:0] fields_seen = '0;
    logic [`CSR_SEQ_COUNT-1:0] field_bit;
    int                field_idx;

    logic [31:0] lcg_state = 32'haf0ea348;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          hold_left = 0;
    logic        hold_expect = 1'b0;

    // Golden file parsing
    int                fd;
    int                code;
    int                line_count;
    string             tag;
    string             line_text;
    logic [2:0]        w_class;
    mem_offset_t       w_offset;
    mem_shift_t        w_shift;
    mem_data_t         w_data;
    logic [3:0]        e_flags;
    logic [31:0]       e_start;
    logic [31:0]       e_end;
    logic [31:0]       e_stride;
    logic [30:0]       e_gran;
    logic              e_dir;
    logic [63:0]       e_ptr;
    logic [31:0]       e_size;
    int                p_cycles;
    logic              p_level;
    memory_response_t  resp_word;
    csr_index_config_t expected;

    always #5 ap_clk = ~ap_clk;

    csr_index_configure_top UUT (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_payload           (response_payload),
        .response_rd_en             (response_rd_en),
        .configuration_rd_en        (configuration_rd_en),
        .configuration_valid        (configuration_valid),
        .configuration_payload      (configuration_payload),
        .response_prog_full         (response_prog_full),
        .configuration_prog_full    (configuration_prog_full)
    );

    // ------------------------------------------------------------
    // Checks and helpers
    // ------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compare_config(input string name, input csr_index_config_t got,
                                  input csr_index_config_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Sequence number of a response word
    function automatic int word_seq(input memory_response_t w);
        return int'(w.offset >> w.shift_amount);
    endfunction

    // Setup class and sequence inside the window
    function automatic logic word_accepted(input memory_response_t w);
        logic setup;
        int   seq;
        setup = (w.buffer_class == class_cu_setup) ||
                (w.buffer_class == class_engine_setup);
        seq   = word_seq(w);
        return setup && (seq >= `CSR_SEQ_MIN) && (seq < `CSR_SEQ_MIN + `CSR_SEQ_COUNT);
    endfunction

    // One clock of stimulus, applied on the falling edge
    task automatic drive_cycle(input logic vld, input memory_response_t pl);
        logic [31:0] r_resp;
        logic [31:0] r_cfg;
        @(negedge ap_clk);
        r_resp           = next_random();
        r_cfg            = next_random();
        response_valid   = vld;
        response_payload = pl;
        response_rd_en   = (r_resp[31:26] != 6'd0);
        if (hold_left > 0) begin
            configuration_rd_en = 1'b0;
            hold_left           = hold_left - 1;
            // Last paused cycle, the queue level is checked here
            if (hold_left == 0) begin
                compare_bit("configuration_prog_full", configuration_prog_full, hold_expect);
            end
        end else begin
            configuration_rd_en = (r_cfg[31:29] != 3'd0);
        end
    endtask

    // ------------------------------------------------------------
    // Monitor and timeout
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && configuration_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                report_failure("Configuration appeared while none was expected");
            end else begin
                compare_config("configuration_payload", configuration_payload,
                               expected_q.pop_front());
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            report_failure("Timeout: expected configurations did not arrive in time");
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        areset_csr_index_generator = 1'b1;
        response_valid             = 1'b0;
        response_payload           = '0;
        response_rd_en             = 1'b0;
        configuration_rd_en        = 1'b0;

        // Run length limit from the size of the golden file
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            report_failure("Could not open the golden file");
        end
        line_count = 0;
        while (!$feof(fd)) begin
            if ($fgets(line_text, fd) != 0) begin
                line_count++;
            end
        end
        $fclose(fd);
        timeout_limit = 40 * line_count + 200;

        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        compare_bit("configuration_valid", configuration_valid, 1'b0);
        compare_bit("response_prog_full", response_prog_full, 1'b0);
        compare_bit("configuration_prog_full", configuration_prog_full, 1'b0);
        areset_csr_index_generator = 1'b0;

        fd = $fopen(GOLDEN_FILE, "r");
        while (1) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                void'($fgets(line_text, fd));
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h %h %h", w_class, w_offset, w_shift, w_data);
                if (code != 4) begin
                    report_failure("Malformed W line in the golden file");
                end
                resp_word              = '0;
                resp_word.buffer_class = buffer_class_t'(w_class);
                resp_word.offset       = w_offset;
                resp_word.shift_amount = w_shift;
                resp_word.data         = w_data;
                if (!word_accepted(resp_word)) begin
                    rejected_q.push_back(resp_word);
                end else begin
                    field_idx            = word_seq(resp_word) - `CSR_SEQ_MIN;
                    field_bit            = '0;
                    field_bit[field_idx] = 1'b1;
                    if ((fields_seen | field_bit) == '1) begin
                        // Every other field is set, so a leaked word would show
                        while (rejected_q.size() != 0) begin
                            drive_cycle(1'b1, rejected_q.pop_front());
                        end
                        fields_seen = '0;
                    end else begin
                        fields_seen = fields_seen | field_bit;
                    end
                    drive_cycle(1'b1, resp_word);
                end
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h", e_flags, e_start, e_end,
                               e_stride, e_gran, e_dir, e_ptr, e_size);
                if (code != 8) begin
                    report_failure("Malformed E line in the golden file");
                end
                expected.flags           = engine_flags_t'(e_flags);
                expected.index_start     = e_start;
                expected.index_end       = e_end;
                expected.stride          = e_stride;
                expected.granularity     = e_gran;
                expected.shift_direction = e_dir;
                expected.array_pointer   = e_ptr;
                expected.array_size      = e_size;
                expected_q.push_back(expected);
            end else if (tag == "P") begin
                code = $fscanf(fd, "%d %h", p_cycles, p_level);
                if (code != 2) begin
                    report_failure("Malformed P line in the golden file");
                end
                hold_left   = p_cycles;
                hold_expect = p_level;
            end else begin
                report_failure("Unknown line type in the golden file");
            end
        end
        $fclose(fd);

        // Rejected words with no set left to land in
        while (rejected_q.size() != 0) begin
            drive_cycle(1'b1, rejected_q.pop_front());
        end

        // Drain, then a quiet stretch to catch extra outputs
        while (expected_q.size() != 0) begin
            drive_cycle(1'b0, '0);
        end
        repeat (20) drive_cycle(1'b0, '0);
        compare_bit("configuration_prog_full", configuration_prog_full, 1'b0);
        compare_bit("response_prog_full", response_prog_full, 1'b0);

        if (expected_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_failure("Expected configurations left over at the end of the run");
        end
    end

endmodule
